/* sim.f */
+incdir+hw
hw/htable_pkg.sv
hw/htable_hash.sv
hw/htable_mem.sv
hw/htable_core.sv
hw/htable_update_dist.sv
hw/htable_multi_core.sv
verification/htable_tb_assertions.sv
verification/htable_tb.sv

/* Bender.yml */
package:
  name: htable_multi

sources:
  - include_dirs:
      - hw
    files:
      - hw/htable_pkg.sv
      - hw/htable_hash.sv
      - hw/htable_mem.sv
      - hw/htable_core.sv
      - hw/htable_update_dist.sv
      - hw/htable_multi_core.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verification/htable_tb_assertions.sv
      - verification/htable_tb.sv

/* verification/htable_tb.sv */
/*
 * Testbench of the multi-table hash engine in round-robin mode.
 * Drives init, insert, overwrite, collision and back-to-back lookup
 * tests and compares each lookup_ack against a reference model.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_tb;
    import htable_pkg::*;

    localparam int N            = `HTABLE_NUM_TABLES;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    // Lookups plus updates over all tests
    localparam int NUM_OPS      = 20 + 60 + 6 + 12 + 40;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + `HTABLE_DEPTH + 2 + NUM_OPS * 6 + 50) * CLK_PERIOD;

    typedef struct packed {
        logic   hit;
        value_t value;
    } lookup_exp_t;

    // DUT signals
    logic   clk = 1'b0;
    logic   rst_n;
    logic   lookup_req;
    logic   lookup_rdy;
    logic   lookup_ack;
    logic   lookup_hit;
    logic   update_req;
    logic   update_rdy;
    logic   update_ack;
    logic   init_done;
    key_t   lookup_key;
    key_t   update_key;
    value_t lookup_value;
    value_t update_value;

    // Reference model with table contents and round-robin pointer
    entry_t model_mem [N][`HTABLE_DEPTH];
    int     rr_ptr;
    bit     key_used [2**`HTABLE_KEY_W];
    key_t   ins_key [30];
    key_t   coll_key [3];

    // Scoreboard and error counters
    lookup_exp_t exp_q [$];
    string       test_q [$];
    int          updates_sent;
    int          update_acks;
    int          lookups_sent;
    int          lookup_acks;
    int          mismatch_count;
    int          other_count;
    int          assert_fails;

    htable_multi_core #(.INSERT_MODE(HTABLE_INSERT_RR)) dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Reference functions
    // --------------------------------------------------
    // Seeded rotate-XOR index of a key in one table
    function automatic index_t hash_index(input key_t key, input int tbl);
        logic [31:0] wide;
        key_t        seed;
        int          rot;
        rot  = (5 * tbl) % `HTABLE_KEY_W;
        wide = {16'h0, key};
        wide = (wide << rot) | (wide >> (`HTABLE_KEY_W - rot));
        seed = (tbl == 0) ? `HTABLE_SEED_0 : (tbl == 1) ? `HTABLE_SEED_1 : `HTABLE_SEED_2;
        return index_t'(wide[15:0] ^ seed);
    endfunction

    // Highest-numbered hitting table gives the value
    function automatic lookup_exp_t expected_lookup(input key_t key);
        lookup_exp_t res;
        entry_t      ent;
        res = '0;
        for (int t = 0; t < N; t++) begin
            ent = model_mem[t][hash_index(key, t)];
            if (ent.valid && ent.key == key) res = '{hit: 1'b1, value: ent.value};
        end
        return res;
    endfunction

    function automatic key_t fresh_key();
        key_t cand;
        cand = key_t'($urandom);
        while (key_used[cand]) cand = key_t'($urandom);
        key_used[cand] = 1'b1;
        return cand;
    endfunction

    // Unused key landing on a given index of a given table
    function automatic key_t colliding_key(input int tbl, input index_t idx);
        key_t cand;
        for (int i = 0; i < (1 << 20); i++) begin
            cand = key_t'($urandom);
            if (!key_used[cand] && hash_index(cand, tbl) == idx) begin
                key_used[cand] = 1'b1;
                return cand;
            end
        end
        other_count++;
        $display("No unused key found for index %0d of table %0d", idx, tbl);
        return cand;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_hit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch in %s: hit expected %0b, actual %0b", test, exp, act);
        end
    endtask

    task automatic check_value(input string test, input value_t exp, input value_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch in %s: value expected %h, actual %h", test, exp, act);
        end
    endtask

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------
    // Hold the update until accepted, then wait for its ack
    task automatic insert_entry(input key_t key, input value_t value);
        update_req   = 1'b1;
        update_key   = key;
        update_value = value;
        @(negedge clk);
        while (!update_rdy) @(negedge clk);
        model_mem[rr_ptr][hash_index(key, rr_ptr)] = '{valid: 1'b1, key: key, value: value};
        rr_ptr = (rr_ptr + 1) % N;
        updates_sent++;
        @(posedge clk);
        #1;
        update_req = 1'b0;
        while (update_acks < updates_sent) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Expected result follows the model as it stands at acceptance
    task automatic issue_lookup(input string test, input key_t key);
        lookup_req = 1'b1;
        lookup_key = key;
        @(negedge clk);
        while (!lookup_rdy) @(negedge clk);
        exp_q.push_back(expected_lookup(key));
        test_q.push_back(test);
        lookups_sent++;
        @(posedge clk);
        #1;
        lookup_req = 1'b0;
    endtask

    task automatic drain_lookups();
        while (exp_q.size() > 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Monitor samples DUT outputs on the falling edge
    always @(negedge clk) begin : monitor
        lookup_exp_t expected;
        string       test;
        if (rst_n) begin
            if (lookup_rdy !== init_done || update_rdy !== init_done) begin
                other_count++;
                $display("Ready does not follow init_done at %0t", $time);
            end
            if (update_ack === 1'b1) update_acks++;
            if (lookup_ack === 1'b1) begin
                lookup_acks++;
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("lookup_ack arrived with no lookup outstanding at %0t", $time);
                end else begin
                    expected = exp_q.pop_front();
                    test     = test_q.pop_front();
                    check_hit(test, expected.hit, lookup_hit);
                    if (expected.hit) check_value(test, expected.value, lookup_value);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : main
        int     init_cycles;
        int     coll_tbl;
        index_t coll_idx;
        key_t   k;
        void'($urandom(32'hcef43464));
        rst_n = 1'b0;
        {lookup_req, update_req} = '0;
        {lookup_key, update_key, update_value} = '0;
        foreach (model_mem[t, i]) model_mem[t][i] = '0;
        rr_ptr = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Init sweep, then lookups into empty tables
        init_cycles = 0;
        while (!init_done) begin
            @(negedge clk);
            init_cycles++;
        end
        if (init_cycles < `HTABLE_DEPTH || init_cycles > `HTABLE_DEPTH + 2) begin
            other_count++;
            $display("init_done came %0d cycles after reset release, outside the sweep time",
                     init_cycles);
        end
        @(posedge clk);
        #1;
        repeat (20) issue_lookup("init", key_t'($urandom));
        drain_lookups();

        // Round-robin insert of distinct keys
        for (int i = 0; i < 30; i++) begin
            ins_key[i] = fresh_key();
            insert_entry(ins_key[i], value_t'($urandom));
        end
        foreach (ins_key[i]) issue_lookup("round_robin", ins_key[i]);
        drain_lookups();

        // Same key again as it walks through the tables
        repeat (3) begin
            insert_entry(ins_key[0], value_t'($urandom));
            issue_lookup("overwrite", ins_key[0]);
        end
        drain_lookups();

        // Three keys share one index of one table while fillers go to the others
        coll_tbl    = rr_ptr;
        coll_key[0] = fresh_key();
        coll_idx    = hash_index(coll_key[0], coll_tbl);
        for (int r = 0; r < 3; r++) begin
            if (r > 0) coll_key[r] = colliding_key(coll_tbl, coll_idx);
            for (int t = 0; t < N; t++) begin
                k = (rr_ptr == coll_tbl) ? coll_key[r] : fresh_key();
                insert_entry(k, value_t'($urandom));
            end
        end
        foreach (coll_key[i]) issue_lookup("collision", coll_key[i]);
        drain_lookups();

        // Lookups on consecutive cycles mixing present and absent keys
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 3)
                0:       k = ins_key[$urandom % 30];
                1:       k = coll_key[$urandom % 3];
                default: k = fresh_key();
            endcase
            issue_lookup("back_to_back", k);
        end
        drain_lookups();

        if (update_acks != updates_sent || lookup_acks != lookups_sent) begin
            other_count++;
            $display("Ack count wrong: %0d/%0d update acks, %0d/%0d lookup acks",
                     update_acks, updates_sent, lookup_acks, lookups_sent);
        end
        assert_fails = dut_i.i_assertions.fail_count;
        $display("Done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, other_count, assert_fails);
        if (mismatch_count + other_count + assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : htable_tb

/* verification/htable_tb_assertions.sv */
/*
 * Concurrent checks on the top level's handshakes, bound into
 * htable_multi_core. Covers quiet acks after reset, ready before init
 * and the fixed lookup and update latencies.
 */
`timescale 1ns/100ps

module htable_tb_assertions (
    input logic clk,
    input logic rst_n,
    input logic lookup_req,
    input logic lookup_rdy,
    input logic lookup_ack,
    input logic update_req,
    input logic update_rdy,
    input logic update_ack,
    input logic init_done
);
    // Number of failed assertions so far
    int fail_count = 0;

    // --------------------------------------------------
    // Reset and init
    // --------------------------------------------------
    // Acks stay quiet for the first cycles after reset release
    assert property (@(posedge clk) $rose(rst_n) |-> (!lookup_ack && !update_ack) [*3])
        else begin
            $error("ack seen within 2 cycles after reset");
            fail_count++;
        end

    // Neither channel is ready before every table is swept
    assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> (!lookup_rdy && !update_rdy))
        else begin
            $error("ready high before init_done");
            fail_count++;
        end

    // --------------------------------------------------
    // Fixed latencies
    // --------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        (lookup_req && lookup_rdy) |-> ##3 lookup_ack)
        else begin
            $error("lookup_ack missing 3 cycles after accept");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (update_req && update_rdy) |-> ##2 update_ack)
        else begin
            $error("update_ack missing 2 cycles after accept");
            fail_count++;
        end

endmodule : htable_tb_assertions

// Attach the checker to every engine instance
bind htable_multi_core htable_tb_assertions i_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup_req (lookup_req),
    .lookup_rdy (lookup_rdy),
    .lookup_ack (lookup_ack),
    .update_req (update_req),
    .update_rdy (update_rdy),
    .update_ack (update_ack),
    .init_done  (init_done)
);

/* hw/htable_multi_core.sv */
/*
 * Multi-table hash lookup engine. Each lookup goes to every table and
 * the answers merge into one hit and value; updates are spread by
 * htable_update_dist. Both channels are ready once all tables are
 * initialized.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_multi_core #(
    parameter htable_pkg::insert_mode_t INSERT_MODE = htable_pkg::HTABLE_INSERT_RR
) (
    input  logic               clk,
    input  logic               rst_n,
    // Lookup request and response
    input  logic               lookup_req,
    input  htable_pkg::key_t   lookup_key,
    output logic               lookup_rdy,
    output logic               lookup_ack,
    output logic               lookup_hit,
    output htable_pkg::value_t lookup_value,
    // Update
    input  logic               update_req,
    input  htable_pkg::key_t   update_key,
    input  htable_pkg::value_t update_value,
    output logic               update_rdy,
    output logic               update_ack,
    // Status
    output logic               init_done
);
    import htable_pkg::*;

    localparam int N = `HTABLE_NUM_TABLES;

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    logic [N-1:0] tbl_init_done;
    logic [N-1:0] tbl_lookup_ack;
    logic [N-1:0] tbl_lookup_hit;
    value_t       tbl_lookup_value [N];
    logic [N-1:0] tbl_update_req;
    logic [N-1:0] tbl_update_ack;

    // Accepted requests
    logic         lookup_acc;
    logic         update_acc;

    // Ready and accept; tables never stall once initialized
    assign init_done  = &tbl_init_done;
    assign lookup_rdy = init_done;
    assign update_rdy = init_done;
    assign lookup_acc = lookup_req && lookup_rdy;
    assign update_acc = update_req && update_rdy;

    // --------------------------------------------------
    // Table array
    // --------------------------------------------------
    for (genvar g_tbl = 0; g_tbl < N; g_tbl++) begin : g_tbl
        htable_core #(.TABLE_ID(g_tbl)) i_htable_core (
            .clk          (clk),
            .rst_n        (rst_n),
            .init_done    (tbl_init_done[g_tbl]),
            .lookup_req   (lookup_acc),
            .lookup_key   (lookup_key),
            .lookup_ack   (tbl_lookup_ack[g_tbl]),
            .lookup_hit   (tbl_lookup_hit[g_tbl]),
            .lookup_value (tbl_lookup_value[g_tbl]),
            .update_req   (tbl_update_req[g_tbl]),
            .update_key   (update_key),
            .update_value (update_value),
            .update_ack   (tbl_update_ack[g_tbl])
        );
    end

    // Update routing per insert mode
    htable_update_dist #(.MODE(INSERT_MODE)) i_update_dist (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_req     (update_acc),
        .tbl_update_req (tbl_update_req),
        .tbl_update_ack (tbl_update_ack),
        .update_ack     (update_ack)
    );

    // --------------------------------------------------
    // Lookup merge
    // --------------------------------------------------
    // Later tables override earlier ones, so the highest hitting table wins
    always_comb begin
        lookup_ack   = |tbl_lookup_ack;
        lookup_hit   = 1'b0;
        lookup_value = '0;
        for (int i = 0; i < N; i++) begin
            if (tbl_lookup_ack[i] && tbl_lookup_hit[i]) begin
                lookup_hit   = 1'b1;
                lookup_value = tbl_lookup_value[i];
            end
        end
    end

endmodule : htable_multi_core

/* hw/htable_update_dist.sv */
/*
 * Spreads application updates over the tables, one table per request in
 * round-robin order or all tables at once in broadcast mode, and folds
 * the table acks back into one update_ack. Outputs are combinational.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_update_dist #(
    parameter htable_pkg::insert_mode_t MODE = htable_pkg::HTABLE_INSERT_RR
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          update_req,
    output logic [`HTABLE_NUM_TABLES-1:0] tbl_update_req,
    input  logic [`HTABLE_NUM_TABLES-1:0] tbl_update_ack,
    output logic                          update_ack
);
    import htable_pkg::*;

    localparam int N     = `HTABLE_NUM_TABLES;
    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    generate
        if (MODE == HTABLE_INSERT_RR) begin : g_rr
            // --------------------------------------------------
            // Round-robin
            // --------------------------------------------------
            logic [PTR_W-1:0] ptr;

            // Advance on every accepted update, wrap after the last table
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    ptr <= '0;
                end else if (update_req) begin
                    ptr <= (ptr == PTR_W'(N - 1)) ? '0 : ptr + 1'b1;
                end
            end

            // Route the request to the selected table only
            for (genvar g_tbl = 0; g_tbl < N; g_tbl++) begin : g_tbl
                assign tbl_update_req[g_tbl] = update_req && (ptr == PTR_W'(g_tbl));
            end

            // Exactly one table acks per request
            assign update_ack = |tbl_update_ack;
        end else begin : g_bcast
            // Broadcast: every table takes every update
            assign tbl_update_req = {N{update_req}};
            // Tables run in lockstep, so table 0 speaks for all
            assign update_ack     = tbl_update_ack[0];
        end
    endgenerate

endmodule : htable_update_dist

/* hw/htable_core.sv */
/*
 * One hash table: init sweep after reset, 3-cycle lookup pipeline and
 * 2-cycle update write path. Requests arrive already qualified by the
 * top, so the core takes every req pulse as accepted.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_core #(
    parameter int TABLE_ID = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               init_done,
    input  logic               lookup_req,
    input  htable_pkg::key_t   lookup_key,
    output logic               lookup_ack,
    output logic               lookup_hit,
    output htable_pkg::value_t lookup_value,
    input  logic               update_req,
    input  htable_pkg::key_t   update_key,
    input  htable_pkg::value_t update_value,
    output logic               update_ack
);
    import htable_pkg::*;

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    // Init sweep
    index_t init_addr;

    // Lookup pipeline
    index_t lk_index;
    logic   lk_v1;
    logic   lk_v2;
    key_t   lk_key1;
    key_t   lk_key2;
    entry_t rd_entry;

    // Update path
    index_t up_index;
    logic   up_v1;
    key_t   up_key1;
    value_t up_val1;
    logic   wr_v;
    index_t wr_index_q;
    entry_t wr_entry_q;

    // Memory write port after the init mux
    logic   mem_wr_en;
    index_t mem_wr_index;
    entry_t mem_wr_entry;

    // --------------------------------------------------
    // Init sweep
    // --------------------------------------------------
    // Walks every address once, writing invalid entries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (init_addr == index_t'(`HTABLE_DEPTH - 1)) begin
                init_done <= 1'b1;
            end else begin
                init_addr <= init_addr + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Lookup pipeline
    // --------------------------------------------------
    // Stage 1: hash registers the read index
    htable_hash #(.TABLE_ID(TABLE_ID)) i_lookup_hash (
        .clk   (clk),
        .rst_n (rst_n),
        .key   (lookup_key),
        .index (lk_index)
    );

    // Valid bits follow the hash and the memory read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_v1      <= 1'b0;
            lk_v2      <= 1'b0;
            lookup_ack <= 1'b0;
            lookup_hit <= 1'b0;
        end else begin
            lk_v1      <= lookup_req;
            lk_v2      <= lk_v1;
            lookup_ack <= lk_v2;
            // Stage 3: stored key must match and entry be valid
            lookup_hit <= lk_v2 && rd_entry.valid && (rd_entry.key == lk_key2);
        end
    end

    // Key and value carried alongside
    always_ff @(posedge clk) begin
        lk_key1      <= lookup_key;
        lk_key2      <= lk_key1;
        lookup_value <= rd_entry.value;
    end

    // --------------------------------------------------
    // Update path
    // --------------------------------------------------
    htable_hash #(.TABLE_ID(TABLE_ID)) i_update_hash (
        .clk   (clk),
        .rst_n (rst_n),
        .key   (update_key),
        .index (up_index)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_v1 <= 1'b0;
            wr_v  <= 1'b0;
        end else begin
            up_v1 <= update_req;
            wr_v  <= up_v1;
        end
    end

    // Stage 2 builds the entry; a collision simply overwrites
    always_ff @(posedge clk) begin
        up_key1    <= update_key;
        up_val1    <= update_value;
        wr_index_q <= up_index;
        wr_entry_q <= '{valid: 1'b1, key: up_key1, value: up_val1};
    end

    // Ack in the cycle the write lands
    assign update_ack = wr_v;

    // Init sweep owns the write port until it finishes
    always_comb begin
        if (!init_done) begin
            mem_wr_en    = 1'b1;
            mem_wr_index = init_addr;
            mem_wr_entry = '0;
        end else begin
            mem_wr_en    = wr_v;
            mem_wr_index = wr_index_q;
            mem_wr_entry = wr_entry_q;
        end
    end

    htable_mem i_mem (
        .clk      (clk),
        .wr_en    (mem_wr_en),
        .wr_index (mem_wr_index),
        .wr_entry (mem_wr_entry),
        .rd_index (lk_index),
        .rd_entry (rd_entry)
    );

endmodule : htable_core

/* hw/htable_mem.sv */
/*
 * Entry memory of one table: one synchronous write port and one read
 * port with a registered output. Contents are cleared by the core's
 * init sweep after reset.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_mem (
    input  logic               clk,
    input  logic               wr_en,
    input  htable_pkg::index_t wr_index,
    input  htable_pkg::entry_t wr_entry,
    input  htable_pkg::index_t rd_index,
    output htable_pkg::entry_t rd_entry
);
    import htable_pkg::*;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    entry_t mem [`HTABLE_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    // Read-before-write on an address clash; the core's
    // pipeline keeps writes ahead of dependent lookups
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_index];
    end

endmodule : htable_mem

/* hw/htable_hash.sv */
/*
 * Registered hash of a key into a table index.
 * Index is the low bits of the key rotated left by 5*TABLE_ID, XORed
 * with that table's seed. One cycle of latency.
 */
`timescale 1ns/100ps
`include "htable_settings.svh"

module htable_hash #(
    parameter int TABLE_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  htable_pkg::key_t  key,
    output htable_pkg::index_t index
);
    import htable_pkg::*;

    // Rotation amount differs per table so each table spreads keys its own way
    localparam int ROT = (5 * TABLE_ID) % `HTABLE_KEY_W;

    // --------------------------------------------------
    // Rotate and seed
    // --------------------------------------------------
    logic [2*`HTABLE_KEY_W-1:0] key_dbl;
    key_t                       key_rot;
    key_t                       key_mix;

    always_comb begin
        // Upper half of the doubled key after the shift is the rotated key
        key_dbl = {key, key} << ROT;
        key_rot = key_dbl[2*`HTABLE_KEY_W-1:`HTABLE_KEY_W];
        key_mix = key_rot ^ hash_seed(TABLE_ID);
    end

    // Register stage, low bits only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else begin
            index <= index_t'(key_mix);
        end
    end

endmodule : htable_hash

/* hw/htable_pkg.sv */
/*
 * Shared types of the hash lookup engine: key, value, index, entry word
 * and the insert mode. Also holds the per-table hash seed lookup.
 */
`include "htable_settings.svh"

package htable_pkg;

    // Basic fields
    typedef logic [`HTABLE_KEY_W-1:0]   key_t;
    typedef logic [`HTABLE_VALUE_W-1:0] value_t;
    typedef logic [`HTABLE_INDEX_W-1:0] index_t;

    // How application updates are spread over the tables
    typedef enum logic {
        HTABLE_INSERT_RR        = 1'b0,
        HTABLE_INSERT_BROADCAST = 1'b1
    } insert_mode_t;

    // One memory word of a table
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } entry_t;

    // --------------------------------------------------
    // Seed of a given table number
    // --------------------------------------------------
    function automatic key_t hash_seed(input int tbl);
        key_t seed;
        case (tbl)
            0:       seed = `HTABLE_SEED_0;
            1:       seed = `HTABLE_SEED_1;
            2:       seed = `HTABLE_SEED_2;
            default: seed = '0;
        endcase
        return seed;
    endfunction

endpackage : htable_pkg

/* hw/htable_settings.svh */
/*
 * Build-time settings of the multi-table hash lookup engine.
 * Include wherever widths, table count or hash seeds are needed.
 */
`ifndef HTABLE_SETTINGS_SVH
`define HTABLE_SETTINGS_SVH

// --------------------------------------------------
// Entry field widths
// --------------------------------------------------
`define HTABLE_KEY_W      16
`define HTABLE_VALUE_W    16

// --------------------------------------------------
// Table geometry
// --------------------------------------------------
`define HTABLE_NUM_TABLES 3
`define HTABLE_DEPTH      64
`define HTABLE_INDEX_W    6

// Per-table hash seeds, XORed into the rotated key
`define HTABLE_SEED_0     16'h5a3c
`define HTABLE_SEED_1     16'h9e37
`define HTABLE_SEED_2     16'h1b6d

`endif
